//--- hdl/tile_defines.svh
`ifndef TILE_DEFINES_SVH
`define TILE_DEFINES_SVH

// byte address carried by a request packet
`define TILE_ADDR_W 32

// store data width
`define TILE_DATA_W 32

// one mask bit per data byte
`define TILE_MASK_W 4

// width of one x or y network coordinate
`define TILE_CORD_W 4

// receive fifo depth in packets
`define TILE_FIFO_ELS 4

// data memory is split into this many banks
`define TILE_NUM_BANKS 4

// words held by each bank
`define TILE_BANK_WORDS 64

// word address bits actually decoded, higher bits alias
// must equal log2(banks) + log2(bank words)
`define TILE_WORD_ADDR_W 8

`endif

//--- hdl/net_pkg.sv
`include "tile_defines.svh"

package net_pkg;

   // opcodes seen on the request network
   // OP_RESERVED is never produced by a legal sender
   typedef enum logic [1:0]
   {
      OP_STORE    = 2'b00,
      OP_FREEZE   = 2'b01,
      OP_UNFREEZE = 2'b10,
      OP_RESERVED = 2'b11
   } net_op_e;

   // request packet as it leaves the network
   typedef struct packed
   {
      net_op_e                 op;
      logic [`TILE_MASK_W-1:0] mask;
      logic [`TILE_ADDR_W-1:0] addr;
      logic [`TILE_DATA_W-1:0] data;
      logic [`TILE_CORD_W-1:0] from_x;
      logic [`TILE_CORD_W-1:0] from_y;
   } net_packet_s;

   // return packet, only the sender coordinates travel back
   typedef struct packed
   {
      logic [`TILE_CORD_W-1:0] from_x;
      logic [`TILE_CORD_W-1:0] from_y;
   } ret_packet_s;

endpackage

//--- hdl/mem_pkg.sv
`include "tile_defines.svh"

package mem_pkg;

   // bank index and row index inside one bank
   typedef logic [$clog2(`TILE_NUM_BANKS)-1:0]  bank_sel_t;
   typedef logic [$clog2(`TILE_BANK_WORDS)-1:0] bank_row_t;

   // word address as seen before the bank swizzle
   // lsb holds the bits that pick the bank
   typedef struct packed
   {
      bank_row_t row;
      bank_sel_t lsb;
   } word_addr_s;

   // one remote store headed for the banked memory
   typedef struct packed
   {
      word_addr_s              addr;
      logic [`TILE_DATA_W-1:0] data;
      logic [`TILE_MASK_W-1:0] mask;
   } mem_wreq_s;

endpackage

//--- hdl/rx_fifo.sv
`timescale 1ns/10ps
`include "tile_defines.svh"

module rx_fifo
(
   input  logic                 clk_i,
   input  logic                 reset_i,
   input  logic                 v_i,
   input  net_pkg::net_packet_s data_i,
   output logic                 ready_o,
   output logic                 head_v_o,
   output net_pkg::net_packet_s head_o,
   input  logic                 yumi_i
);

   localparam int ptr_w_lp = $clog2(`TILE_FIFO_ELS);
   localparam int cnt_w_lp = $clog2(`TILE_FIFO_ELS + 1);

   // packet storage, no reset needed on payload
   net_pkg::net_packet_s mem_r [`TILE_FIFO_ELS];
   logic [ptr_w_lp-1:0]  wptr_r;
   logic [ptr_w_lp-1:0]  rptr_r;
   logic [cnt_w_lp-1:0]  count_r;
   logic                 enq;
   logic                 deq;

   // pointer step with wrap, depth need not be a power of two
   function automatic logic [ptr_w_lp-1:0] next_ptr(input logic [ptr_w_lp-1:0] p);
      if (p == ptr_w_lp'(`TILE_FIFO_ELS - 1))
         return '0;
      return p + 1'b1;
   endfunction

   // accept while there is a free slot
   assign ready_o  = (count_r < cnt_w_lp'(`TILE_FIFO_ELS));
   assign enq      = v_i & ready_o;
   // consumer only raises yumi while head is valid
   assign deq      = yumi_i;
   assign head_v_o = (count_r != '0);
   // head is read straight out of storage
   assign head_o   = mem_r[rptr_r];

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         wptr_r  <= '0;
         rptr_r  <= '0;
         count_r <= '0;
      end
      else
      begin
         if (enq)
            wptr_r <= next_ptr(wptr_r);
         if (deq)
            rptr_r <= next_ptr(rptr_r);
         // occupancy holds when both or neither happen
         case ({enq, deq})
            2'b10:   count_r <= count_r + 1'b1;
            2'b01:   count_r <= count_r - 1'b1;
            default: count_r <= count_r;
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (enq)
         mem_r[wptr_r] <= data_i;
   end

endmodule

//--- hdl/pkt_decode.sv
`timescale 1ns/10ps
`include "tile_defines.svh"

module pkt_decode
(
   input  logic                 clk_i,
   input  logic                 reset_i,
   input  logic                 head_v_i,
   input  net_pkg::net_packet_s head_i,
   output logic                 yumi_o,
   output logic                 freeze_o,
   output logic                 wreq_v_o,
   output mem_pkg::mem_wreq_s   wreq_o,
   output net_pkg::ret_packet_s ret_o,
   input  logic                 wreq_yumi_i
);

   logic                 is_store;
   logic                 is_freeze;
   logic                 is_unfreeze;
   logic                 is_unknown;
   logic                 slot_free;
   logic                 pop_store;
   logic                 freeze_r;
   logic                 wreq_v_r;
   mem_pkg::mem_wreq_s   wreq_r;
   net_pkg::ret_packet_s ret_r;

   // sort the head packet by opcode
   always_comb
   begin
      is_store    = 1'b0;
      is_freeze   = 1'b0;
      is_unfreeze = 1'b0;
      is_unknown  = 1'b0;
      if (head_v_i)
      begin
         case (head_i.op)
            net_pkg::OP_STORE:    is_store    = 1'b1;
            net_pkg::OP_FREEZE:   is_freeze   = 1'b1;
            net_pkg::OP_UNFREEZE: is_unfreeze = 1'b1;
            // OP_RESERVED and anything else is simply dropped
            default:              is_unknown  = 1'b1;
         endcase
      end
   end

   // holding register frees up in the cycle its store commits
   assign slot_free = ~wreq_v_r | wreq_yumi_i;
   assign pop_store = is_store & slot_free;
   // freeze types and unknowns never wait
   assign yumi_o    = pop_store | is_freeze | is_unfreeze | is_unknown;

   // tile comes out of reset frozen
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         freeze_r <= 1'b1;
      else if (is_freeze)
         freeze_r <= 1'b1;
      else if (is_unfreeze)
         freeze_r <= 1'b0;
   end

   // pending flag for the one-entry store slot
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         wreq_v_r <= 1'b0;
      else if (pop_store)
         wreq_v_r <= 1'b1;
      else if (wreq_yumi_i)
         wreq_v_r <= 1'b0;
   end

   // store payload, only the decoded word address bits are kept
   always_ff @(posedge clk_i)
   begin
      if (pop_store)
      begin
         wreq_r.addr  <= head_i.addr[2 +: `TILE_WORD_ADDR_W];
         wreq_r.data  <= head_i.data;
         wreq_r.mask  <= head_i.mask;
         ret_r.from_x <= head_i.from_x;
         ret_r.from_y <= head_i.from_y;
      end
   end

   assign freeze_o = freeze_r;
   assign wreq_v_o = wreq_v_r;
   assign wreq_o   = wreq_r;
   assign ret_o    = ret_r;

endmodule

//--- hdl/bank_mem.sv
`timescale 1ns/10ps
`include "tile_defines.svh"

module bank_mem
(
   input  logic                         clk_i,
   input  logic                         reset_i,
   input  logic                         wreq_v_i,
   input  mem_pkg::mem_wreq_s           wreq_i,
   input  net_pkg::ret_packet_s         ret_i,
   output logic                         wreq_yumi_o,
   input  logic                         ret_ready_i,
   output logic                         ret_v_o,
   output net_pkg::ret_packet_s         ret_data_o,
   input  logic                         rd_v_i,
   input  logic [`TILE_WORD_ADDR_W-1:0] rd_addr_i,
   output logic                         rd_v_o,
   output logic [`TILE_DATA_W-1:0]      rd_data_o
);

   localparam int num_banks_lp  = `TILE_NUM_BANKS;
   localparam int bank_words_lp = `TILE_BANK_WORDS;
   localparam int byte_w_lp     = `TILE_DATA_W / `TILE_MASK_W;

   mem_pkg::word_addr_s rd_addr;
   mem_pkg::word_addr_s wr_addr;
   mem_pkg::bank_sel_t  rd_bank;
   mem_pkg::bank_sel_t  wr_bank;
   mem_pkg::bank_sel_t  rd_bank_r;
   logic                conflict;
   logic                commit;
   logic                rd_v_r;
   // per-bank read data, each element driven from its own bank
   logic [num_banks_lp-1:0][`TILE_DATA_W-1:0] bank_rdata;

   // bank swizzle, the low word address bits pick the bank in reversed order
   function automatic mem_pkg::bank_sel_t bank_of(input mem_pkg::word_addr_s a);
      mem_pkg::bank_sel_t b;
      b = {<<{a.lsb}};
      return b;
   endfunction

   assign rd_addr = rd_addr_i;
   assign wr_addr = wreq_i.addr;
   assign rd_bank = bank_of(rd_addr);
   assign wr_bank = bank_of(wr_addr);

   // local read wins its bank, the store waits a cycle
   assign conflict = rd_v_i & (rd_bank == wr_bank);
   // no commit unless the return packet can leave now
   assign commit   = wreq_v_i & ret_ready_i & ~conflict;

   assign wreq_yumi_o = commit;
   // one return packet per committed store
   assign ret_v_o     = commit;
   assign ret_data_o  = ret_i;

   for (genvar b = 0; b < num_banks_lp; b++)
   begin : g_bank
      logic [`TILE_DATA_W-1:0] words_r [bank_words_lp];
      logic [`TILE_DATA_W-1:0] rdata_r;
      logic                    wr_hit;
      logic                    rd_hit;

      assign wr_hit = commit & (wr_bank == mem_pkg::bank_sel_t'(b));
      assign rd_hit = rd_v_i & (rd_bank == mem_pkg::bank_sel_t'(b));

      always_ff @(posedge clk_i)
      begin
         // masked byte write on commit
         if (wr_hit)
         begin
            for (int j = 0; j < `TILE_MASK_W; j++)
            begin
               if (wreq_i.mask[j])
                  words_r[wr_addr.row][byte_w_lp*j +: byte_w_lp] <=
                     wreq_i.data[byte_w_lp*j +: byte_w_lp];
            end
         end
         // synchronous read, never in the same bank as a write
         if (rd_hit)
            rdata_r <= words_r[rd_addr.row];
      end

      assign bank_rdata[b] = rdata_r;
   end

   // read valid, one cycle after the request
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         rd_v_r <= 1'b0;
      else
         rd_v_r <= rd_v_i;
   end

   // remember which bank answers
   always_ff @(posedge clk_i)
   begin
      if (rd_v_i)
         rd_bank_r <= rd_bank;
   end

   assign rd_v_o    = rd_v_r;
   assign rd_data_o = bank_rdata[rd_bank_r];

endmodule

//--- hdl/manycore_tile.sv
`timescale 1ns/10ps
`include "tile_defines.svh"

module manycore_tile
(
   input  logic                         clk_i,
   input  logic                         reset_i,
   input  logic                         v_i,
   input  net_pkg::net_packet_s         data_i,
   output logic                         ready_o,
   output logic                         ret_v_o,
   output net_pkg::ret_packet_s         ret_data_o,
   input  logic                         ret_ready_i,
   input  logic                         rd_v_i,
   input  logic [`TILE_WORD_ADDR_W-1:0] rd_addr_i,
   output logic                         rd_v_o,
   output logic [`TILE_DATA_W-1:0]      rd_data_o,
   output logic                         freeze_o
);

   // fifo head towards decode
   logic                 head_v;
   net_pkg::net_packet_s head;
   logic                 head_yumi;
   // pending store towards the banks
   logic                 wreq_v;
   mem_pkg::mem_wreq_s   wreq;
   net_pkg::ret_packet_s wreq_ret;
   logic                 wreq_yumi;

   rx_fifo rx_fifo
   (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .v_i      (v_i),
      .data_i   (data_i),
      .ready_o  (ready_o),
      .head_v_o (head_v),
      .head_o   (head),
      .yumi_i   (head_yumi)
   );

   pkt_decode pkt_decode
   (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .head_v_i    (head_v),
      .head_i      (head),
      .yumi_o      (head_yumi),
      .freeze_o    (freeze_o),
      .wreq_v_o    (wreq_v),
      .wreq_o      (wreq),
      .ret_o       (wreq_ret),
      .wreq_yumi_i (wreq_yumi)
   );

   bank_mem bank_mem
   (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .wreq_v_i    (wreq_v),
      .wreq_i      (wreq),
      .ret_i       (wreq_ret),
      .wreq_yumi_o (wreq_yumi),
      .ret_ready_i (ret_ready_i),
      .ret_v_o     (ret_v_o),
      .ret_data_o  (ret_data_o),
      .rd_v_i      (rd_v_i),
      .rd_addr_i   (rd_addr_i),
      .rd_v_o      (rd_v_o),
      .rd_data_o   (rd_data_o)
   );

endmodule

//--- sim/tb_manycore_tile.sv
`timescale 1ns/10ps
`include "tile_defines.svh"

module tb_manycore_tile;

   // about 560 packets at a few cycles each plus stall bursts stay far below this
   localparam int timeout_cycles_lp = 20000;
   localparam int words_lp          = 1 << `TILE_WORD_ADDR_W;
   localparam int rand_pkts_lp      = 300;
   localparam int byte_w_lp         = `TILE_DATA_W / `TILE_MASK_W;
   // fifo plus one pending store drain in a handful of cycles once ret_ready_i stays high
   localparam int drain_cycles_lp   = 64;

   logic                         clk_i;
   logic                         reset_i;
   logic                         v_i;
   net_pkg::net_packet_s         data_i;
   logic                         ready_o;
   logic                         ret_v_o;
   net_pkg::ret_packet_s         ret_data_o;
   logic                         ret_ready_i;
   logic                         rd_v_i;
   logic [`TILE_WORD_ADDR_W-1:0] rd_addr_i;
   logic                         rd_v_o;
   logic [`TILE_DATA_W-1:0]      rd_data_o;
   logic                         freeze_o;

   // reference model state
   logic [`TILE_DATA_W-1:0] model_mem [words_lp];
   net_pkg::net_packet_s    store_q [$];
   logic                    freeze_q [$];
   logic                    freeze_cur;
   logic                    freeze_last;
   logic                    rd_exp_v;
   logic [`TILE_DATA_W-1:0] rd_exp_data;

   integer seed;
   int     cycles;
   int     full_cycles;
   int     err_read;
   int     err_ret;
   int     err_freeze;
   int     err_misc;

   manycore_tile DUT
   (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .v_i         (v_i),
      .data_i      (data_i),
      .ready_o     (ready_o),
      .ret_v_o     (ret_v_o),
      .ret_data_o  (ret_data_o),
      .ret_ready_i (ret_ready_i),
      .rd_v_i      (rd_v_i),
      .rd_addr_i   (rd_addr_i),
      .rd_v_o      (rd_v_o),
      .rd_data_o   (rd_data_o),
      .freeze_o    (freeze_o)
   );

   // 4 ns clock
   initial
   begin
      clk_i = 1'b0;
      forever
         #2 clk_i = ~clk_i;
   end

   task automatic print_counts();
      $display("errors: %0d total (read %0d, return %0d, freeze %0d, other %0d)",
               err_read + err_ret + err_freeze + err_misc,
               err_read, err_ret, err_freeze, err_misc);
   endtask

   // hang guard counting rising edges
   initial
   begin
      cycles = 0;
      while (cycles < timeout_cycles_lp)
      begin
         @(posedge clk_i);
         cycles++;
      end
      $display("timeout: run did not finish within %0d cycles, the DUT seems hung", cycles);
      print_counts();
      $display("=== FAIL ===");
      $finish;
   end

   // every field random and the caller fixes what it needs
   function automatic net_pkg::net_packet_s random_packet(input net_pkg::net_op_e op);
      net_pkg::net_packet_s p;
      p.op     = op;
      p.mask   = $random(seed);
      p.addr   = $random(seed);
      p.data   = $random(seed);
      p.from_x = $random(seed);
      p.from_y = $random(seed);
      return p;
   endfunction

   // masked write of one committed store into the model
   task automatic apply_store(input net_pkg::net_packet_s st);
      mem_pkg::word_addr_s w;
      // only the decoded word bits count so upper address bits alias
      w = st.addr[2 +: `TILE_WORD_ADDR_W];
      for (int j = 0; j < `TILE_MASK_W; j++)
      begin
         if (st.mask[j])
            model_mem[w][byte_w_lp*j +: byte_w_lp] = st.data[byte_w_lp*j +: byte_w_lp];
      end
   endtask

   // queue what a packet accepted by the fifo should cause
   task automatic record_packet(input net_pkg::net_packet_s pkt);
      case (pkt.op)
         net_pkg::OP_STORE:
            store_q.push_back(pkt);
         net_pkg::OP_FREEZE:
         begin
            freeze_q.push_back(1'b1);
            freeze_last = 1'b1;
         end
         net_pkg::OP_UNFREEZE:
         begin
            freeze_q.push_back(1'b0);
            freeze_last = 1'b0;
         end
         // reserved opcode is dropped without any effect
         default:
            ;
      endcase
   endtask

   // one cycle from a falling edge that drives, settles, checks and updates the model
   task automatic run_cycle(input logic send, input net_pkg::net_packet_s pkt,
                            input logic rd_en, input logic [`TILE_WORD_ADDR_W-1:0] rd_addr,
                            input logic ret_rdy, output logic accepted);
      net_pkg::net_packet_s st;
      net_pkg::ret_packet_s exp_ret;
      logic                 dummy;
      // packets go out only while the fifo has room
      v_i         = send & ready_o;
      data_i      = pkt;
      rd_v_i      = rd_en;
      rd_addr_i   = rd_addr;
      ret_ready_i = ret_rdy;
      if (ready_o !== 1'b1)
         full_cycles++;
      #1;
      // response to the read sampled one edge ago
      if (rd_v_o !== rd_exp_v)
      begin
         $display("ERR %0t: rd_v_o is %b, expected %b", $time, rd_v_o, rd_exp_v);
         err_read++;
      end
      else if (rd_exp_v && rd_data_o !== rd_exp_data)
      begin
         $display("ERR %0t: rd_data_o is %h, expected %h", $time, rd_data_o, rd_exp_data);
         err_read++;
      end
      // expectation taken before stores that commit on this edge
      rd_exp_v = rd_en;
      if (rd_en)
         rd_exp_data = model_mem[rd_addr];
      // freeze level may only move to the next queued level
      if (freeze_o !== freeze_cur)
      begin
         // skip packets that repeat the current level
         while (freeze_q.size() > 0 && freeze_q[0] === freeze_cur)
            dummy = freeze_q.pop_front();
         if (freeze_q.size() == 0 || freeze_q[0] !== freeze_o)
         begin
            $display("ERR %0t: freeze_o went to %b without a matching packet", $time, freeze_o);
            err_freeze++;
         end
         else
            dummy = freeze_q.pop_front();
         freeze_cur = freeze_o;
      end
      // return pulse means the oldest store commits on this edge
      if (ret_v_o !== 1'b0)
      begin
         if (ret_ready_i !== 1'b1)
         begin
            $display("ERR %0t: ret_v_o high while ret_ready_i is low", $time);
            err_ret++;
         end
         if (store_q.size() == 0)
         begin
            $display("ERR %0t: ret_v_o high with no store outstanding", $time);
            err_ret++;
         end
         else
         begin
            st             = store_q.pop_front();
            exp_ret.from_x = st.from_x;
            exp_ret.from_y = st.from_y;
            if (ret_data_o !== exp_ret)
            begin
               $display("ERR %0t: ret_data_o is %h, expected %h", $time, ret_data_o, exp_ret);
               err_ret++;
            end
            apply_store(st);
         end
      end
      accepted = v_i;
      if (v_i)
         record_packet(pkt);
      @(negedge clk_i);
   endtask

   initial
   begin
      net_pkg::net_packet_s pkt;
      net_pkg::net_op_e     op;
      logic [31:0]          rnd;
      logic                 acc;
      int                   idx;
      int                   sent;
      seed        = 32'hcf6e_c23e;
      reset_i     = 1'b1;
      v_i         = 1'b0;
      data_i      = '0;
      ret_ready_i = 1'b0;
      rd_v_i      = 1'b0;
      rd_addr_i   = '0;
      freeze_cur  = 1'b1;
      freeze_last = 1'b1;
      rd_exp_v    = 1'b0;
      full_cycles = 0;
      err_read    = 0;
      err_ret     = 0;
      err_freeze  = 0;
      err_misc    = 0;
      repeat (5) @(posedge clk_i);
      @(negedge clk_i);
      // state held by reset since nothing moves on a falling edge
      if (freeze_o !== 1'b1 || ret_v_o !== 1'b0 || rd_v_o !== 1'b0 || ready_o !== 1'b1)
      begin
         $display("ERR %0t: reset state freeze %b ret_v %b rd_v %b ready %b", $time,
                  freeze_o, ret_v_o, rd_v_o, ready_o);
         err_misc++;
      end
      reset_i = 1'b0;

      // full-word store to every word with random upper bits for aliasing
      idx = 0;
      while (idx < words_lp)
      begin
         rnd  = $random(seed);
         pkt  = random_packet(net_pkg::OP_STORE);
         pkt.mask = '1;
         pkt.addr[2 +: `TILE_WORD_ADDR_W] = idx[`TILE_WORD_ADDR_W-1:0];
         run_cycle(1'b1, pkt, 1'b0, '0, rnd[1:0] != 2'b00, acc);
         if (acc)
            idx++;
      end
      while (store_q.size() > 0)
         run_cycle(1'b0, pkt, 1'b0, '0, 1'b1, acc);

      // mixed traffic with reads and return stalls
      sent = 0;
      while (sent < rand_pkts_lp)
      begin
         rnd = $random(seed);
         case (rnd[3:0])
            4'd0:    op = net_pkg::OP_FREEZE;
            4'd1:    op = net_pkg::OP_UNFREEZE;
            4'd2:    op = net_pkg::OP_RESERVED;
            default: op = net_pkg::OP_STORE;
         endcase
         pkt = random_packet(op);
         // a stall burst every 64 cycles lets the fifo fill up
         run_cycle(rnd[5:4] != 2'b00, pkt, rnd[6], rnd[23:16],
                   rnd[25:24] != 2'b00 && (cycles % 64) < 48, acc);
         if (acc)
            sent++;
      end

      // bounded drain so a lost return packet is left in the queue
      idx = 0;
      while (store_q.size() > 0 && idx < drain_cycles_lp)
      begin
         run_cycle(1'b0, pkt, 1'b0, '0, 1'b1, acc);
         idx++;
      end
      // trailing freeze packets settle
      repeat (8) run_cycle(1'b0, pkt, 1'b0, '0, 1'b1, acc);

      if (store_q.size() != 0)
      begin
         $display("ERR %0t: %0d stores never returned", $time, store_q.size());
         err_ret++;
      end
      if (freeze_o !== freeze_last)
      begin
         $display("ERR %0t: final freeze_o %b, expected %b", $time, freeze_o, freeze_last);
         err_freeze++;
      end
      if (full_cycles == 0)
      begin
         $display("ready_o never fell, so the full receive FIFO case was not reached");
         err_misc++;
      end

      print_counts();
      if (err_read + err_ret + err_freeze + err_misc == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

//--- manycore_tile.f
+incdir+hdl
hdl/net_pkg.sv
hdl/mem_pkg.sv
hdl/rx_fifo.sv
hdl/pkt_decode.sv
hdl/bank_mem.sv
hdl/manycore_tile.sv
sim/tb_manycore_tile.sv
